/* verilog/cnn_pkg.sv */
`default_nettype none

package cnn_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int WORD_W    = 32;  // data / weight / output word
	localparam int HALF_W    = 16;  // one signed element, one lane result
	localparam int ACC_W     = 40;  // mac accumulator
	localparam int FRAC_BITS = 8;   // fixed point fraction of a conv result
	localparam int OP_NUM_W  = 16;  // word pairs per output
	localparam int OUT_CNT_W = 16;  // outputs per operation

	// saturation limits of a lane result
	localparam int HALF_MAX = (2 ** (HALF_W - 1)) - 1;
	localparam int HALF_MIN = -(2 ** (HALF_W - 1));

	// ----------------------------------------
	// operation descriptor
	// ----------------------------------------
	typedef enum logic [1:0] {
		OP_CONV    = 2'd0,  // 3x3 or 1x1 conv by multiply-accumulate
		OP_MAXPOOL = 2'd1   // max over data halves
	} op_type_e;

	typedef struct packed {
		op_type_e               op_type;
		logic [OP_NUM_W-1:0]    op_num;     // >= 1
		logic [OUT_CNT_W-1:0]   out_count;  // >= 1
	} op_desc_t;

	// ----------------------------------------
	// streams
	// ----------------------------------------
	// each word carries two signed halves with element 0 in the low half
	typedef struct packed {
		logic [WORD_W-1:0] data;
		logic [WORD_W-1:0] weight;
	} lane_in_t;

	// lane1 in the upper half
	typedef struct packed {
		logic signed [HALF_W-1:0] lane1;
		logic signed [HALF_W-1:0] lane0;
	} result_t;

endpackage

`default_nettype wire

/* verilog/cmd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_ctrl import cnn_pkg::*; (
	input  wire                 i_clk,
	input  wire                 i_rst,

	// descriptor in
	input  op_desc_t            i_cmd,
	input  wire                 i_cmd_valid,
	output logic                o_cmd_ready,

	// one pulse per output word leaving the core
	input  wire                 i_out_fire,

	// to both lanes
	output op_desc_t            o_op,
	output logic                o_busy,
	output logic                o_done     // completion pulse
);

	op_desc_t               op_q;
	logic                   busy_q;
	logic                   done_q;
	logic [OUT_CNT_W-1:0]   out_cnt_q;     // outputs sent so far

	logic                   cmd_fire;
	logic                   last_out;

	assign o_cmd_ready = ~busy_q;          // one op at a time
	assign cmd_fire    = i_cmd_valid & o_cmd_ready;
	assign last_out    = i_out_fire & (out_cnt_q == op_q.out_count - 1'b1);

	// ----------------------------------------
	// descriptor register
	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		if (cmd_fire) begin
			op_q <= i_cmd;
		end
	end

	// ----------------------------------------
	// busy / output count / done
	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			busy_q    <= 1'b0;
			done_q    <= 1'b0;
			out_cnt_q <= '0;
		end else begin
			done_q <= 1'b0;                    // single cycle pulse
			if (cmd_fire) begin
				busy_q    <= 1'b1;
				out_cnt_q <= '0;
			end else if (busy_q && i_out_fire) begin
				if (last_out) begin
					busy_q    <= 1'b0;         // ready for next command
					done_q    <= 1'b1;
					out_cnt_q <= '0;
				end else begin
					out_cnt_q <= out_cnt_q + 1'b1;
				end
			end
		end
	end

	assign o_op   = op_q;
	assign o_busy = busy_q;
	assign o_done = done_q;

endmodule

`default_nettype wire

/* verilog/lane_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_unit import cnn_pkg::*; (
	input  wire                         i_clk,
	input  wire                         i_rst,

	// operation from the controller
	input  op_desc_t                    i_op,
	input  wire                         i_busy,

	// data/weight pair stream
	input  lane_in_t                    i_in,
	input  wire                         i_in_valid,
	output logic                        o_in_ready,

	// result to the merger
	output logic signed [HALF_W-1:0]    o_res,
	output logic                        o_res_valid,
	input  wire                         i_res_take
);

	// clamp a wide value into the signed half range
	function automatic logic signed [HALF_W-1:0] sat_half(input logic signed [ACC_W-1:0] v);
		logic signed [HALF_W-1:0] r;
		if (v > HALF_MAX) begin
			r = HALF_W'(HALF_MAX);
		end else if (v < HALF_MIN) begin
			r = HALF_W'(HALF_MIN);
		end else begin
			r = v[HALF_W-1:0];
		end
		return r;
	endfunction

	logic [OP_NUM_W-1:0]        pair_cnt_q;
	logic signed [ACC_W-1:0]    acc_q;         // running sum or running max
	logic signed [HALF_W-1:0]   res_q;
	logic                       res_valid_q;

	logic                       in_fire;
	logic                       first_pair;
	logic                       last_pair;

	logic signed [HALF_W-1:0]   d0, d1, w0, w1;
	logic signed [ACC_W-1:0]    prod0, prod1;
	logic signed [ACC_W-1:0]    d0_ext, d1_ext;
	logic signed [ACC_W-1:0]    mac_next;
	logic signed [ACC_W-1:0]    max_base, max_pair, max_next;
	logic signed [ACC_W-1:0]    acc_next;
	logic signed [HALF_W-1:0]   res_next;

	// ----------------------------------------
	// handshake
	// ----------------------------------------
	assign o_in_ready = i_busy & (~res_valid_q | i_res_take);  // full result stalls input
	assign in_fire    = i_in_valid & o_in_ready;
	assign first_pair = (pair_cnt_q == '0);
	assign last_pair  = (pair_cnt_q == i_op.op_num - 1'b1);

	// ----------------------------------------
	// datapath
	// ----------------------------------------
	assign d0 = i_in.data[HALF_W-1:0];
	assign d1 = i_in.data[WORD_W-1:HALF_W];
	assign w0 = i_in.weight[HALF_W-1:0];
	assign w1 = i_in.weight[WORD_W-1:HALF_W];

	assign prod0    = d0 * w0;
	assign prod1    = d1 * w1;
	assign mac_next = (first_pair ? '0 : acc_q) + prod0 + prod1;

	// pooling ignores the weights
	assign d0_ext   = d0;
	assign d1_ext   = d1;
	assign max_base = first_pair ? ACC_W'(HALF_MIN) : acc_q;
	assign max_pair = (d0_ext > d1_ext) ? d0_ext : d1_ext;
	assign max_next = (max_pair > max_base) ? max_pair : max_base;

	assign acc_next = (i_op.op_type == OP_MAXPOOL) ? max_next : mac_next;
	assign res_next = (i_op.op_type == OP_MAXPOOL) ? sat_half(acc_next)
	                                               : sat_half(acc_next >>> FRAC_BITS);

	always_ff @(posedge i_clk) begin
		if (in_fire) begin
			acc_q <= acc_next;
			if (last_pair) begin
				res_q <= res_next;         // final value of this output
			end
		end
	end

	// ----------------------------------------
	// control
	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			pair_cnt_q  <= '0;
			res_valid_q <= 1'b0;
		end else begin
			if (!i_busy) begin
				pair_cnt_q <= '0;
			end else if (in_fire) begin
				pair_cnt_q <= last_pair ? '0 : pair_cnt_q + 1'b1;  // restart per output
			end

			if (in_fire && last_pair) begin
				res_valid_q <= 1'b1;
			end else if (i_res_take) begin
				res_valid_q <= 1'b0;
			end
		end
	end

	assign o_res       = res_q;
	assign o_res_valid = res_valid_q;

endmodule

`default_nettype wire

/* verilog/result_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module result_merge import cnn_pkg::*; (
	input  wire                         i_clk,
	input  wire                         i_rst,

	// lane results
	input  wire signed [HALF_W-1:0]     i_res0,
	input  wire                         i_res0_valid,
	input  wire signed [HALF_W-1:0]     i_res1,
	input  wire                         i_res1_valid,
	output logic                        o_take,        // both lanes at once

	// output stream
	output result_t                     o_result,
	output logic                        o_result_valid,
	input  wire                         i_result_ready,

	// to the controller
	output logic                        o_out_fire
);

	result_t    result_q;
	logic       valid_q;

	logic       out_fire;
	logic       can_load;
	logic       take;

	assign out_fire = valid_q & i_result_ready;
	assign can_load = ~valid_q | i_result_ready;   // empty or draining this cycle
	assign take     = i_res0_valid & i_res1_valid & can_load;

	// ----------------------------------------
	// output holding register
	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		if (take) begin
			result_q.lane0 <= i_res0;
			result_q.lane1 <= i_res1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			valid_q <= 1'b0;
		end else if (take) begin
			valid_q <= 1'b1;
		end else if (out_fire) begin
			valid_q <= 1'b0;
		end
	end

	assign o_take         = take;
	assign o_result       = result_q;
	assign o_result_valid = valid_q;
	assign o_out_fire     = out_fire;

endmodule

`default_nettype wire

/* verilog/squeeze_core.sv */
`timescale 1ns/1ps
`default_nettype none

module squeeze_core import cnn_pkg::*; (
	input  wire             okClk,
	input  wire             i_rst,

	// command
	input  op_desc_t        i_cmd,
	input  wire             i_cmd_valid,
	output logic            o_cmd_ready,

	// lane 0 data/weight
	input  lane_in_t        i_lane0,
	input  wire             i_lane0_valid,
	output logic            o_lane0_ready,

	// lane 1 data/weight
	input  lane_in_t        i_lane1,
	input  wire             i_lane1_valid,
	output logic            o_lane1_ready,

	// packed results
	output result_t         o_result,
	output logic            o_result_valid,
	input  wire             i_result_ready,

	output logic            o_done
);

	op_desc_t                   op;
	logic                       busy;
	logic signed [HALF_W-1:0]   res0, res1;
	logic                       res0_valid, res1_valid;
	logic                       take;
	logic                       out_fire;

	// ----------------------------------------
	// command block
	// ----------------------------------------
	cmd_ctrl cmd_ctrl_inst (
		.i_clk          (okClk),
		.i_rst          (i_rst),
		.i_cmd          (i_cmd),
		.i_cmd_valid    (i_cmd_valid),
		.o_cmd_ready    (o_cmd_ready),
		.i_out_fire     (out_fire),
		.o_op           (op),
		.o_busy         (busy),
		.o_done         (o_done)
	);

	// ----------------------------------------
	// compute lanes
	// ----------------------------------------
	lane_unit lane0_inst (
		.i_clk          (okClk),
		.i_rst          (i_rst),
		.i_op           (op),
		.i_busy         (busy),
		.i_in           (i_lane0),
		.i_in_valid     (i_lane0_valid),
		.o_in_ready     (o_lane0_ready),
		.o_res          (res0),
		.o_res_valid    (res0_valid),
		.i_res_take     (take)         // shared strobe
	);

	lane_unit lane1_inst (
		.i_clk          (okClk),
		.i_rst          (i_rst),
		.i_op           (op),
		.i_busy         (busy),
		.i_in           (i_lane1),
		.i_in_valid     (i_lane1_valid),
		.o_in_ready     (o_lane1_ready),
		.o_res          (res1),
		.o_res_valid    (res1_valid),
		.i_res_take     (take)
	);

	// ----------------------------------------
	// result packing
	// ----------------------------------------
	result_merge result_merge_inst (
		.i_clk          (okClk),
		.i_rst          (i_rst),
		.i_res0         (res0),
		.i_res0_valid   (res0_valid),
		.i_res1         (res1),
		.i_res1_valid   (res1_valid),
		.o_take         (take),
		.o_result       (o_result),
		.o_result_valid (o_result_valid),
		.i_result_ready (i_result_ready),
		.o_out_fire     (out_fire)     // counted by cmd_ctrl
	);

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic o_clk
);

	localparam realtime HALF_PERIOD = 4.0;  // 8 ns period

	initial begin
		o_clk = 1'b0;
	end

	always begin
		#(HALF_PERIOD);
		o_clk = ~o_clk;
	end

endmodule

`default_nettype wire

/* dv/squeeze_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module squeeze_core_tb import cnn_pkg::*; ();

	localparam int      N_TESTS   = 7;
	localparam int      MAX_WORDS = 128;  // pairs per lane per test
	localparam int      CLK_NS    = 8;
	localparam int      MARGIN    = 10;   // cycles allowed per word pair
	localparam int      SLACK     = 400;  // reset and command overhead

	typedef struct {
		string      name;
		op_type_e   op;
		int         op_num;
		int         out_count;
		bit         stall;   // random back-pressure on the result stream
		int         sat;     // 0 random, 1 all 0x7fff, 2 data 0x8000
	} test_row_t;

	logic       okClk;
	logic       i_rst;
	op_desc_t   i_cmd;
	logic       i_cmd_valid, o_cmd_ready;
	lane_in_t   i_lane0, i_lane1;
	logic       i_lane0_valid, o_lane0_ready;
	logic       i_lane1_valid, o_lane1_ready;
	result_t    o_result;
	logic       o_result_valid, i_result_ready;
	logic       o_done;

	test_row_t  tests [N_TESTS];
	test_row_t  cur;
	lane_in_t   stim [2][MAX_WORDS];
	bit         gap_bit [MAX_WORDS];   // idle cycle before a lane1 word
	bit         stall_bit [64];
	logic [31:0] lfsr_q;

	tb_clk_gen clk_gen_inst (.o_clk(okClk));

	squeeze_core squeeze_core_inst (
		.okClk          (okClk),
		.i_rst          (i_rst),
		.i_cmd          (i_cmd),
		.i_cmd_valid    (i_cmd_valid),
		.o_cmd_ready    (o_cmd_ready),
		.i_lane0        (i_lane0),
		.i_lane0_valid  (i_lane0_valid),
		.o_lane0_ready  (o_lane0_ready),
		.i_lane1        (i_lane1),
		.i_lane1_valid  (i_lane1_valid),
		.o_lane1_ready  (o_lane1_ready),
		.o_result       (o_result),
		.o_result_valid (o_result_valid),
		.i_result_ready (i_result_ready),
		.o_done         (o_done)
	);

	// ----------------------------------------
	// failure and compare helpers
	// ----------------------------------------
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic cmp_result(input string tag, input result_t exp, input result_t act);
		if (act !== exp) begin
			abort_run($sformatf("ERR %s %s: expected %h actual %h", cur.name, tag, exp, act));
		end
	endtask

	task automatic cmp_bit(input string tag, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("ERR %s %s: expected %b actual %b", cur.name, tag, exp, act));
		end
	endtask

	// ----------------------------------------
	// random source
	// ----------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);  // galois taps 32 30 26 25
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v      = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	task automatic rand_half(output logic [15:0] h);
		logic [31:0] b;
		rand_bits(10, b);
		h = {{6{b[9]}}, b[9:0]};  // small signed values keep most sums in range
	endtask

	task automatic gen_stim();
		logic [15:0] h [4];
		logic [31:0] b;
		for (int lane = 0; lane < 2; lane++) begin
			for (int k = 0; k < cur.op_num * cur.out_count; k++) begin
				for (int q = 0; q < 4; q++) begin
					rand_half(h[q]);
				end
				case (cur.sat)
					1:       stim[lane][k] = '{data: 32'h7fff_7fff, weight: 32'h7fff_7fff};
					2:       stim[lane][k] = '{data: 32'h8000_8000, weight: 32'h7fff_7fff};
					default: stim[lane][k] = '{data: {h[1], h[0]}, weight: {h[3], h[2]}};
				endcase
			end
		end
		for (int k = 0; k < MAX_WORDS; k++) begin
			rand_bits(1, b);
			gap_bit[k] = b[0];
		end
		for (int k = 0; k < 64; k++) begin
			rand_bits(1, b);
			stall_bit[k] = b[0];
		end
	endtask

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic logic signed [15:0] expect_half(input int lane, input int j);
		longint acc;
		lane_in_t w;
		logic signed [15:0] d0, d1, w0, w1;
		acc = (cur.op == OP_MAXPOOL) ? -32768 : 0;
		for (int i = 0; i < cur.op_num; i++) begin
			w  = stim[lane][j * cur.op_num + i];
			d0 = w.data[15:0];
			d1 = w.data[31:16];
			w0 = w.weight[15:0];
			w1 = w.weight[31:16];
			if (cur.op == OP_MAXPOOL) begin
				if (longint'(d0) > acc) acc = d0;
				if (longint'(d1) > acc) acc = d1;
			end else begin
				acc = acc + longint'(d0) * longint'(w0) + longint'(d1) * longint'(w1);
			end
		end
		if (cur.op == OP_CONV) acc = acc >>> 8;  // drop fraction bits
		if (acc > 32767) acc = 32767;
		else if (acc < -32768) acc = -32768;
		return 16'(acc);
	endfunction

	// ----------------------------------------
	// stream drivers entered at posedge + 1 ns
	// ----------------------------------------
	task automatic set_lane(input int lane, input lane_in_t w, input logic v);
		if (lane == 0) begin
			i_lane0       = w;
			i_lane0_valid = v;
		end else begin
			i_lane1       = w;
			i_lane1_valid = v;
		end
	endtask

	task automatic drive_lane(input int lane, input bit paced);
		int   k;
		logic rdy;
		k = 0;
		while (k < cur.op_num * cur.out_count) begin
			if (paced && gap_bit[k]) begin
				set_lane(lane, '0, 1'b0);
				@(posedge okClk);
				#1;
			end
			set_lane(lane, stim[lane][k], 1'b1);
			do begin
				@(negedge okClk);
				rdy = (lane == 0) ? o_lane0_ready : o_lane1_ready;
				@(posedge okClk);
				#1;
			end while (!rdy);
			k++;
		end
		set_lane(lane, '0, 1'b0);
	endtask

	task automatic collect();
		int      got;
		int      sidx;
		logic    fire;
		result_t exp;
		got  = 0;
		sidx = 0;
		while (got < cur.out_count) begin
			i_result_ready = cur.stall ? stall_bit[sidx % 64] : 1'b1;
			sidx++;
			@(negedge okClk);
			fire = o_result_valid & i_result_ready;
			cmp_bit("done before last output", 1'b0, o_done);
			if (fire) begin
				exp.lane0 = expect_half(0, got);
				exp.lane1 = expect_half(1, got);
				cmp_result($sformatf("output %0d", got), exp, o_result);
			end
			@(posedge okClk);
			#1;
			if (fire) got++;
		end
		i_result_ready = 1'b0;
		@(negedge okClk);
		cmp_bit("done pulse", 1'b1, o_done);
		cmp_bit("cmd ready after done", 1'b1, o_cmd_ready);
		cmp_bit("lane0 ready after done", 1'b0, o_lane0_ready);
		cmp_bit("lane1 ready after done", 1'b0, o_lane1_ready);
		@(posedge okClk);
		#1;
		@(negedge okClk);
		cmp_bit("done single cycle", 1'b0, o_done);
		@(posedge okClk);
		#1;
	endtask

	task automatic run_test();
		gen_stim();
		i_cmd       = '{op_type: cur.op, op_num: 16'(cur.op_num), out_count: 16'(cur.out_count)};
		i_cmd_valid = 1'b1;
		@(negedge okClk);
		cmp_bit("cmd ready", 1'b1, o_cmd_ready);
		@(posedge okClk);
		#1;
		i_cmd_valid = 1'b0;
		fork
			drive_lane(0, 1'b0);
			drive_lane(1, 1'b1);  // lane1 paced by random gaps
			collect();
		join
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		longint words;
		longint limit_ns;
		i_rst          = 1'b1;
		i_cmd          = '0;
		i_cmd_valid    = 1'b0;
		i_lane0        = '0;
		i_lane0_valid  = 1'b0;
		i_lane1        = '0;
		i_lane1_valid  = 1'b0;
		i_result_ready = 1'b0;
		lfsr_q         = 32'h885e_0ac3;

		tests[0] = '{"conv3x3",      OP_CONV,    9, 1,  1'b0, 0};
		tests[1] = '{"maxpool",      OP_MAXPOOL, 9, 2,  1'b0, 0};
		tests[2] = '{"conv1x1_multi", OP_CONV,   1, 6,  1'b0, 0};
		tests[3] = '{"maxpool_stall", OP_MAXPOOL, 4, 8, 1'b1, 0};
		tests[4] = '{"conv_stall",   OP_CONV,    3, 10, 1'b1, 0};
		tests[5] = '{"sat_pos",      OP_CONV,    9, 1,  1'b0, 1};
		tests[6] = '{"sat_neg",      OP_CONV,    9, 2,  1'b1, 2};

		words = 0;
		for (int t = 0; t < N_TESTS; t++) begin
			words += tests[t].op_num * tests[t].out_count;
		end
		limit_ns = (words * MARGIN + SLACK) * CLK_NS;
		fork
			begin
				#(limit_ns * 1ns);
				abort_run("timeout: the tests did not finish in the allowed time");
			end
		join_none

		repeat (5) @(posedge okClk);
		#1;
		i_rst = 1'b0;

		cur.name = "reset";
		@(negedge okClk);
		cmp_bit("cmd ready", 1'b1, o_cmd_ready);
		cmp_bit("result valid", 1'b0, o_result_valid);
		cmp_bit("done", 1'b0, o_done);
		cmp_bit("lane0 ready", 1'b0, o_lane0_ready);
		cmp_bit("lane1 ready", 1'b0, o_lane1_ready);
		@(posedge okClk);
		#1;

		for (int t = 0; t < N_TESTS; t++) begin
			cur = tests[t];
			run_test();
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
verilog/cnn_pkg.sv
verilog/cmd_ctrl.sv
verilog/lane_unit.sv
verilog/result_merge.sv
verilog/squeeze_core.sv
dv/tb_clk_gen.sv
dv/squeeze_core_tb.sv

/* Bender.yml */
package:
  name: squeeze_core

sources:
  # design
  - files:
      - verilog/cnn_pkg.sv
      - verilog/cmd_ctrl.sv
      - verilog/lane_unit.sv
      - verilog/result_merge.sv
      - verilog/squeeze_core.sv

  # testbench
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/squeeze_core_tb.sv
